//--- serpc.f
src/serpc_cfg_pkg.sv
src/serpc_isa_pkg.sv
src/serpc_sequencer.sv
src/serpc_decode.sv
src/serpc_imm_shift.sv
src/serpc_pc_unit.sv
src/serpc_link_reg.sv
src/serpc_top.sv
test/serpc_assertions.sv
test/serpc_tb.sv

//--- src/serpc_cfg_pkg.sv
package serpc_cfg_pkg;

   // ####################################################################
   // core constants
   // ####################################################################

   localparam logic [31:0] reset_pc = 32'h0000_0000;
   localparam logic [31:0] trap_vec = 32'h0000_0100;  // illegal word lands here
   localparam int          xlen     = 32;
   localparam int          cnt_w    = 5;               // 32 serial steps

   typedef enum logic [1:0] {
      s_fetch,
      s_decode,
      s_exec,
      s_retire
   } seq_state_t;

   // ####################################################################
   // bus and pipeline bundles
   // ####################################################################

   typedef struct packed {
      logic [xlen-1:0] adr;
      logic            cyc;
      logic            stb;
      logic            we;
   } wb_m2s_t;

   typedef struct packed {
      logic [xlen-1:0] dat;
      logic            ack;
   } wb_s2m_t;

   typedef struct packed {
      logic en;      // any exec step
      logic first;   // step 0
      logic bit2;    // step 2 where the +4 goes in
      logic last;    // step 31
   } cnt_t;

   typedef struct packed {
      logic            valid;
      logic [xlen-1:0] pc;
      logic [xlen-1:0] next_pc;
      logic            rd_we;
      logic [xlen-1:0] rd_data;
      logic            trap;
      logic            misaligned;
   } retire_t;

endpackage

//--- src/serpc_decode.sv
`timescale 1ns/10ps

module serpc_decode
   import serpc_isa_pkg::*;
(
   input  logic [31:0] i_instr,
   output dec_t        o_dec
);

   logic [4:0] major;
   opcode_t    op;
   logic       illegal;
   logic       is_jal;
   logic       is_u;

   assign major   = i_instr[6:2];
   assign illegal = (i_instr[1:0] != 2'b11);  // compressed space not supported

   always_comb begin
      case (major)
         op_jal:   op = op_jal;
         op_lui:   op = op_lui;
         op_auipc: op = op_auipc;
         default:  op = op_other;
      endcase
   end

   assign is_jal = (op == op_jal);
   assign is_u   = (op == op_lui) | (op == op_auipc);

   // ####################################################################
   // control bits where trap wins
   // ####################################################################

   always_comb begin
      o_dec.op     = op;
      o_dec.trap   = illegal;
      o_dec.jump   = is_jal & ~illegal;
      o_dec.utype  = is_u & ~illegal;
      o_dec.pc_rel = is_jal | (op == op_auipc);  // lui adds to zero
      o_dec.rd_we  = (is_jal | is_u) & ~illegal;
   end

endmodule

//--- src/serpc_imm_shift.sv
`timescale 1ns/10ps

module serpc_imm_shift
   import serpc_cfg_pkg::*;
   import serpc_isa_pkg::*;
(
   input  logic            clk,
   input  logic            i_rst_n,
   input  logic [xlen-1:0] i_instr,
   input  dec_t            i_dec,
   input  logic            i_load,
   input  cnt_t            i_cnt,
   output logic            o_imm
);

   logic [xlen-1:0] imm_q;
   logic [xlen-1:0] imm_j;
   logic [xlen-1:0] imm_u;

   // J layout is sign then [19:12] [20] [30:21] and a zero lsb
   assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
   assign imm_u = {i_instr[31:12], 12'b0};

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         imm_q <= '0;
      end else if (i_load) begin
         imm_q <= i_dec.jump ? imm_j : imm_u;
      end else if (i_cnt.en) begin
         imm_q <= {imm_q[xlen-1], imm_q[xlen-1:1]};  // lsb first
      end
   end

   assign o_imm = imm_q[0];

endmodule

//--- src/serpc_isa_pkg.sv
package serpc_isa_pkg;

   // major opcode from instr[6:2]
   typedef enum logic [4:0] {
      op_jal   = 5'b11011,
      op_lui   = 5'b01101,
      op_auipc = 5'b00101,
      op_other = 5'b11111   // everything else
   } opcode_t;

   typedef struct packed {
      opcode_t op;
      logic    jump;     // next pc from offset adder
      logic    utype;    // rd from offset adder
      logic    pc_rel;   // pc feeds offset adder
      logic    rd_we;
      logic    trap;     // low bits not 2'b11
   } dec_t;

endpackage

//--- src/serpc_link_reg.sv
`timescale 1ns/10ps

module serpc_link_reg
   import serpc_cfg_pkg::*;
   import serpc_isa_pkg::*;
(
   input  logic            clk,
   input  logic            i_rst_n,
   input  cnt_t            i_cnt,
   input  dec_t            i_dec,
   input  logic            i_rd_bit,
   input  logic [xlen-1:0] i_pc,
   input  logic            i_misaligned,
   input  logic            i_retire_stb,
   output retire_t         o_retire
);

   logic [xlen-1:0] rd_q;
   logic [xlen-1:0] pc_q;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         rd_q <= '0;
         pc_q <= '0;
      end else begin
         if (i_cnt.en)
            rd_q <= {i_rd_bit, rd_q[xlen-1:1]};
         if (i_cnt.first)
            pc_q <= i_pc;  // still the old pc here
      end
   end

   always_comb begin
      o_retire.valid      = i_retire_stb;
      o_retire.pc         = pc_q;
      o_retire.next_pc    = i_pc;  // fully rotated by now
      o_retire.rd_we      = i_dec.rd_we;
      o_retire.rd_data    = rd_q;
      o_retire.trap       = i_dec.trap;
      o_retire.misaligned = i_misaligned;
   end

endmodule

//--- src/serpc_pc_unit.sv
`timescale 1ns/10ps

module serpc_pc_unit
   import serpc_cfg_pkg::*;
   import serpc_isa_pkg::*;
(
   input  logic            clk,
   input  logic            i_rst_n,
   input  cnt_t            i_cnt,
   input  dec_t            i_dec,
   input  logic            i_imm,
   output logic [xlen-1:0] o_pc,
   output logic            o_pc_bit,
   output logic            o_rd_bit,
   output logic            o_misaligned
);

   logic [xlen-1:0] pc_q;
   logic [xlen-1:0] tv_q;     // rotating copy of trap_vec
   logic            cy4_q;
   logic            cyo_q;
   logic            first_q;
   logic            mis_q;
   logic            pc_bit;
   logic            sum4, cy4;
   logic            sumo, cyo;
   logic            off_a;
   logic            new_bit;

   assign pc_bit = pc_q[0];
   assign off_a  = i_dec.pc_rel & pc_bit;

   // ####################################################################
   // serial adders
   // ####################################################################

   assign {cy4, sum4} = pc_bit + i_cnt.bit2 + (cy4_q & ~i_cnt.first);
   assign {cyo, sumo} = off_a + i_imm + (cyo_q & ~i_cnt.first);

   assign new_bit = i_dec.trap ? tv_q[0] :
                    i_dec.jump ? sumo    : sum4;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pc_q    <= reset_pc;
         tv_q    <= trap_vec;
         cy4_q   <= 1'b0;
         cyo_q   <= 1'b0;
         first_q <= 1'b0;
         mis_q   <= 1'b0;
      end else begin
         first_q <= i_cnt.first;
         if (i_cnt.en) begin
            pc_q  <= {new_bit, pc_q[xlen-1:1]};  // new pc enters at the top
            tv_q  <= {tv_q[0], tv_q[xlen-1:1]};
            cy4_q <= cy4;
            cyo_q <= cyo;
         end
         if (first_q)
            mis_q <= i_dec.jump & sumo;  // target bit 1
      end
   end

   assign o_pc         = pc_q;
   assign o_pc_bit     = pc_bit;
   assign o_rd_bit     = (i_dec.utype & sumo) | (i_dec.jump & sum4);
   assign o_misaligned = mis_q;

endmodule

//--- src/serpc_sequencer.sv
`timescale 1ns/10ps

module serpc_sequencer
   import serpc_cfg_pkg::*;
   import serpc_isa_pkg::*;
(
   input  logic            clk,
   input  logic            i_rst_n,
   input  wb_s2m_t         i_wb,
   input  dec_t            i_dec,
   output logic            o_wb_req,
   output logic [xlen-1:0] o_instr,
   output logic            o_load,
   output cnt_t            o_cnt,
   output logic            o_retire_stb
);

   seq_state_t       state_q;
   logic [cnt_w-1:0] cnt_q;
   logic             req_q;
   logic [xlen-1:0]  instr_q;
   logic             take;
   logic             exec;

   assign take = req_q & i_wb.ack;  // only valid while requesting
   assign exec = (state_q == s_exec);

   // ####################################################################
   // state machine
   // ####################################################################

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q <= s_fetch;
         cnt_q   <= '0;
         req_q   <= 1'b0;
      end else begin
         case (state_q)
            s_fetch: begin
               if (take) begin
                  req_q   <= 1'b0;
                  state_q <= s_decode;
               end else begin
                  req_q <= 1'b1;  // hold cyc/stb until ack
               end
            end
            s_decode: begin
               cnt_q   <= '0;
               state_q <= s_exec;
            end
            s_exec: begin
               cnt_q <= cnt_q + 1'b1;
               if (o_cnt.last)
                  state_q <= s_retire;
            end
            s_retire: begin
               req_q   <= 1'b1;  // next fetch right away
               state_q <= s_fetch;
            end
            default: state_q <= s_fetch;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (take)
         instr_q <= i_wb.dat;
   end

   always_comb begin
      o_cnt.en    = exec;
      o_cnt.first = exec & (cnt_q == cnt_w'(0));
      o_cnt.bit2  = exec & (cnt_q == cnt_w'(2));
      o_cnt.last  = exec & (cnt_q == cnt_w'(xlen - 1));
   end

   assign o_wb_req     = req_q;
   assign o_instr      = instr_q;
   assign o_load       = (state_q == s_decode) & (i_dec.jump | i_dec.utype);  // only if imm used
   assign o_retire_stb = (state_q == s_retire);

endmodule

//--- src/serpc_top.sv
`timescale 1ns/10ps

module serpc_top
   import serpc_cfg_pkg::*;
   import serpc_isa_pkg::*;
(
   input  logic    clk,
   input  logic    i_rst_n,
   output wb_m2s_t o_wb,
   input  wb_s2m_t i_wb,
   output retire_t o_retire
);

   logic            wb_req;
   logic [xlen-1:0] instr;
   logic            load;
   cnt_t            cnt;
   logic            retire_stb;
   dec_t            dec;
   logic            imm_bit;
   logic [xlen-1:0] pc;
   logic            rd_bit;
   logic            misaligned;

   // read-only master with the address straight from the pc register
   assign o_wb = '{adr: pc, cyc: wb_req, stb: wb_req, we: 1'b0};

   // ####################################################################
   // control
   // ####################################################################

   serpc_sequencer u_seq (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_wb         (i_wb),
      .i_dec        (dec),
      .o_wb_req     (wb_req),
      .o_instr      (instr),
      .o_load       (load),
      .o_cnt        (cnt),
      .o_retire_stb (retire_stb)
   );

   serpc_decode u_dec (.i_instr(instr), .o_dec(dec));

   // ####################################################################
   // datapath
   // ####################################################################

   serpc_imm_shift u_imm (
      .clk(clk), .i_rst_n(i_rst_n), .i_instr(instr), .i_dec(dec),
      .i_load(load), .i_cnt(cnt), .o_imm(imm_bit)
   );

   serpc_pc_unit u_pc (
      .clk(clk), .i_rst_n(i_rst_n), .i_cnt(cnt), .i_dec(dec), .i_imm(imm_bit),
      .o_pc(pc), .o_pc_bit(), .o_rd_bit(rd_bit), .o_misaligned(misaligned)
   );

   serpc_link_reg u_link (
      .clk(clk), .i_rst_n(i_rst_n), .i_cnt(cnt), .i_dec(dec),
      .i_rd_bit(rd_bit), .i_pc(pc), .i_misaligned(misaligned),
      .i_retire_stb(retire_stb), .o_retire(o_retire)
   );

endmodule

//--- test/serpc_assertions.sv
`timescale 1ns/10ps

module serpc_assertions
   import serpc_cfg_pkg::*;
(
   input logic    clk,
   input logic    i_rst_n,
   input wb_m2s_t i_wb_m2s,
   input wb_s2m_t i_wb_s2m,
   input retire_t i_retire
);

   int fail_cnt = 0;  // failed assertion count

   a_req_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_wb_m2s.cyc && !i_wb_s2m.ack |=> i_wb_m2s.cyc && $stable(i_wb_m2s.adr))
      else begin
         $error("fetch request or address changed before ack");
         fail_cnt++;
      end

   a_ack_to_retire: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_wb_m2s.cyc && i_wb_s2m.ack |-> ##34 i_retire.valid)  // decode + 32 exec + retire
      else begin
         $error("retire did not follow ack after 34 cycles");
         fail_cnt++;
      end

   a_retire_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_retire.valid |=> !i_retire.valid)
      else begin
         $error("retire valid longer than one cycle");
         fail_cnt++;
      end

   a_quiet_reset: assert property (@(posedge clk)
      !i_rst_n |-> !i_wb_m2s.cyc && !i_retire.valid)
      else begin
         $error("bus cycle or retire active during reset");
         fail_cnt++;
      end

endmodule

bind serpc_top serpc_assertions u_sva (
   .clk(clk), .i_rst_n(i_rst_n), .i_wb_m2s(o_wb), .i_wb_s2m(i_wb), .i_retire(o_retire)
);

//--- test/serpc_tb.sv
`timescale 1ns/10ps

module serpc_tb
   import serpc_cfg_pkg::*;
();

   localparam int n_instr   = 8;
   localparam int max_cycle = n_instr * 60 + 100;

   logic        clk = 1'b0;
   logic        rst_n;
   wb_m2s_t     wb_m2s;
   wb_s2m_t     wb_s2m;
   retire_t     ret;
   logic [31:0] mem [0:1023];
   logic [1:0]  wait_left;
   integer      seed = 32'h36cb974f;
   int          cycles = 0;
   int          errors = 0;
   int          test_err = 0;
   int          tests = 0;
   logic [31:0] pc_m;  // model pc

   always #4 clk = ~clk;

   serpc_top i_dut (
      .clk(clk), .i_rst_n(rst_n), .o_wb(wb_m2s), .i_wb(wb_s2m), .o_retire(ret)
   );

   // ####################################################################
   // wishbone memory with 0 to 3 wait cycles per fetch
   // ####################################################################

   always @(posedge clk) begin
      if (!rst_n) begin
         wb_s2m.ack <= 1'b0;
      end else if (wb_s2m.ack) begin
         wb_s2m.ack <= 1'b0;  // single-cycle ack
      end else if (wb_m2s.cyc && wb_m2s.stb) begin
         if (wait_left == 2'd0) begin
            wb_s2m.ack <= 1'b1;
            wb_s2m.dat <= mem[wb_m2s.adr[11:2]];
            wait_left  <= 2'($random(seed));
         end else begin
            wait_left <= wait_left - 2'd1;
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycle) begin
         $display("timeout: no retire within %0d cycles", max_cycle);
         $display("test failed");
         $finish;
      end
   end

   // ####################################################################
   // helpers
   // ####################################################################

   task automatic place_word(input logic [31:0] word);
      mem[pc_m[11:2]] = word;
   endtask

   task automatic compare(input string name, input string field,
                          input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("FAILED %s %s: expected %h actual %h", name, field, exp, act);
         test_err++;
      end
   endtask

   task automatic wait_retire();
      @(negedge clk);
      while (!ret.valid)
         @(negedge clk);
   endtask

   task automatic wait_fetch();
      @(negedge clk);
      while (!wb_m2s.cyc)
         @(negedge clk);
   endtask

   task automatic check_fetch(input string name, input logic [31:0] adr);
      wait_fetch();
      compare(name, "fetch adr", adr, wb_m2s.adr);
      compare(name, "fetch stb", 32'd1, wb_m2s.stb);
      compare(name, "fetch we", 32'd0, wb_m2s.we);
   endtask

   task automatic expect_retire(input string name, input logic [31:0] nxt, input logic rd_we,
                                input logic [31:0] rd, input logic trap, input logic mis);
      wait_retire();
      compare(name, "pc", pc_m, ret.pc);
      compare(name, "next_pc", nxt, ret.next_pc);
      compare(name, "rd_we", rd_we, ret.rd_we);
      if (rd_we)
         compare(name, "rd_data", rd, ret.rd_data);
      compare(name, "trap", trap, ret.trap);
      compare(name, "misaligned", mis, ret.misaligned);
      pc_m = nxt;
   endtask

   task automatic close_test(input string name);
      tests++;
      errors += test_err;
      $display("%s: %0d mismatches", name, test_err);
      test_err = 0;
   endtask

   function automatic logic [31:0] enc_jal(input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};  // rd = x1
   endfunction

   // ####################################################################
   // directed tests
   // ####################################################################

   task automatic reset_fetch();
      pc_m = reset_pc;
      place_word(32'h0050_0093);  // addi x1, x0, 5
      @(negedge clk);
      if (wb_m2s.cyc || ret.valid) begin
         $display("reset: cyc or retire valid is high while reset is asserted");
         test_err++;
      end
      @(posedge clk);
      rst_n <= 1'b1;
      check_fetch("reset", reset_pc);
      expect_retire("reset", pc_m + 4, 1'b0, 32'h0, 1'b0, 1'b0);
      close_test("reset");
   endtask

   task automatic lui_imm();
      place_word({20'habcde, 5'd5, 7'b0110111});
      expect_retire("lui", pc_m + 4, 1'b1, 32'habcde000, 1'b0, 1'b0);
      close_test("lui");
   endtask

   task automatic auipc_offset();
      place_word({20'h12345, 5'd5, 7'b0010111});
      expect_retire("auipc", pc_m + 4, 1'b1, pc_m + 32'h12345000, 1'b0, 1'b0);
      close_test("auipc");
   endtask

   task automatic jal_jumps();
      logic [20:0] offs [3];
      logic [31:0] tgt;
      offs = '{21'h00040, 21'h1fffe0, 21'h0001e};  // forward, backward, bit 1 set
      foreach (offs[i]) begin
         place_word(enc_jal(offs[i]));
         tgt = pc_m + {{11{offs[i][20]}}, offs[i]};
         expect_retire("jal", tgt, 1'b1, pc_m + 4, 1'b0, tgt[1]);
      end
      close_test("jal");
   endtask

   task automatic illegal_trap();
      place_word(32'h1234_5670);  // low bits 00
      expect_retire("illegal", trap_vec, 1'b0, 32'h0, 1'b1, 1'b0);
      place_word(32'h0050_0093);
      check_fetch("illegal", trap_vec);
      expect_retire("illegal", pc_m + 4, 1'b0, 32'h0, 1'b0, 1'b0);
      close_test("illegal");
   endtask

   initial begin
      rst_n     = 1'b0;
      wb_s2m    = '0;
      wait_left = 2'd0;
      reset_fetch();
      lui_imm();
      auipc_offset();
      jal_jumps();
      illegal_trap();
      errors += i_dut.u_sva.fail_cnt;
      $display("%0d tests run, %0d errors, %0d assertion failures",
               tests, errors, i_dut.u_sva.fail_cnt);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule
